// File: udp_arp_tx.f
+incdir+tb
logic/udp_tx_pkg.sv
logic/payload_intake.sv
logic/word_fifo.sv
logic/checksum_calc.sv
logic/frame_serializer.sv
logic/udp_arp_tx.sv
tb/tb_clock_gen.sv
tb/tb_udp_arp_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the udp_arp_tx testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_udp_arp_tx -Mdir obj_dir -f udp_arp_tx.f \
    && ./obj_dir/Vtb_udp_arp_tx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && exit 0 || exit 1

// File: tb/tb_tests.svh
task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t: %s is %02h, expected %02h", $time, what, got, exp);
        err_cnt++;
    end
endtask

task automatic check_len(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        err_cnt++;
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        err_cnt++;
    end
endtask

task automatic begin_test(input logic [47:0] mac, input logic [31:0] ip);
    errs_before = err_cnt;
    got_q.delete();
    got_last_q.delete();
    exp_q.delete();
    exp_last_q.delete();
    frames_done  = 0;
    done_cnt     = 0;
    stall_cnt    = 0;
    i_target_mac = mac;
    i_target_ip  = ip;
endtask

task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == errs_before) begin
        $display("%s: passed", name);
    end else begin
        fail_cnt++;
        $display("%s: failed with %0d errors", name, err_cnt - errs_before);
    end
endtask

task automatic make_payload(input int nwords);
    pay_q.delete();
    for (int i = 0; i < nwords; i++) pay_q.push_back({$urandom, $urandom});
endtask

// One word per accepted beat, wready sampled mid-cycle
task automatic send_payload();
    logic accepted;
    foreach (pay_q[i]) begin
        i_wdata  = pay_q[i];
        i_wvalid = 1'b1;
        i_wlast  = (i == pay_q.size() - 1);
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge axi_clk);
            accepted = o_wready;
            @(posedge axi_clk);
            #2;
        end
    end
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
endtask

task automatic pulse_arp();
    i_arp_req = 1'b1;
    @(posedge axi_clk);
    #2;
    i_arp_req = 1'b0;
endtask

task automatic wait_frames(input int count);
    while (frames_done < count) @(posedge axi_clk);
    #2;
endtask

task automatic compare_stream();
    check_len(16'(got_q.size()), 16'(exp_q.size()), "Byte count");
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
        check_byte(got_q[i], exp_q[i], $sformatf("Byte %0d", i));
        check_bit(got_last_q[i], exp_last_q[i], $sformatf("o_tlast at byte %0d", i));
    end
endtask

task automatic test_reset_state();
    begin_test(48'h0, 32'h0);
    @(negedge axi_clk);
    check_bit(o_wready, 1'b1, "o_wready after reset");
    check_bit(o_tvalid, 1'b0, "o_tvalid after reset");
    check_bit(o_tlast, 1'b0, "o_tlast after reset");
    check_bit(o_done, 1'b0, "o_done after reset");
    @(posedge axi_clk);
    #2;
    report_test("reset state");
endtask

task automatic test_single_frame();
    begin_test(48'h00_11_22_33_44_55, 32'hC0A8_0001);
    make_payload(3);
    build_udp_frame(i_target_mac, i_target_ip);
    send_payload();
    wait_frames(1);
    compare_stream();
    check_len(16'(done_cnt), 16'd1, "o_done pulses");
    report_test("single UDP frame");
endtask

task automatic test_back_to_back();
    begin_test(48'h00_0C_29_AB_CD_EF, 32'h0A00_0207);
    make_payload(1);
    build_udp_frame(i_target_mac, i_target_ip);
    send_payload();
    make_payload(16);                  // Second frame follows with no idle beat
    build_udp_frame(i_target_mac, i_target_ip);
    send_payload();
    wait_frames(2);
    compare_stream();
    check_len(16'(done_cnt), 16'd2, "o_done pulses");
    report_test("back-to-back frames");
endtask

task automatic test_back_pressure();
    begin_test(48'h3C_52_82_10_20_30, 32'hAC10_FE01);
    rand_ready = 1'b1;
    make_payload(4);
    build_udp_frame(i_target_mac, i_target_ip);
    send_payload();
    wait_frames(1);
    rand_ready = 1'b0;
    compare_stream();
    check_bit(stall_cnt > 0, 1'b1, "Ready low while a byte was offered");
    report_test("back-pressure");
endtask

task automatic test_arp_reply();
    begin_test(48'hF0_DE_F1_12_34_56, 32'hC0A8_00FE);
    build_arp_reply(i_target_mac, i_target_ip);
    @(posedge axi_clk);
    #2;
    pulse_arp();
    wait_frames(1);
    compare_stream();
    report_test("ARP reply");
endtask

task automatic test_arp_behind_udp();
    begin_test(48'h00_50_56_C0_00_08, 32'hC0A8_0A0B);
    make_payload(2);
    build_udp_frame(i_target_mac, i_target_ip);
    build_arp_reply(i_target_mac, i_target_ip);
    send_payload();
    @(negedge axi_clk);
    while (!o_tvalid) @(negedge axi_clk);
    @(posedge axi_clk);
    #2;
    check_len(16'(frames_done), 16'd0, "Frames finished before the ARP request");
    pulse_arp();
    wait_frames(2);
    compare_stream();
    report_test("ARP pending behind UDP");
endtask

// File: tb/tb_udp_arp_tx.sv
`timescale 1ns/1ps

module tb_udp_arp_tx;
    import udp_tx_pkg::*;

    // Frame bytes over all tests, each allowed 200 cycles
    localparam int          BYTES_SENT     = 66 + 50 + 170 + 74 + 42 + 100;
    localparam int          TIMEOUT_CYCLES = 200 * BYTES_SENT + 1000;
    localparam logic [31:0] SEED           = 32'h8e37_a096;

    logic              axi_clk;
    logic              axi_rstn;
    logic [DATA_W-1:0] i_wdata;
    logic              i_wvalid;
    logic              i_wlast;
    logic              o_wready;
    logic              o_done;
    logic              i_arp_req;
    logic [47:0]       i_target_mac;
    logic [31:0]       i_target_ip;
    byte_t             o_tdata;
    logic              o_tvalid;
    logic              o_tlast;
    logic              i_tready;

    byte_t             got_q[$];
    logic              got_last_q[$];
    byte_t             exp_q[$];
    logic              exp_last_q[$];
    logic [63:0]       pay_q[$];
    logic [15:0]       next_id;        // Identification the next UDP frame should carry
    logic              rand_ready;
    logic              hold_pending;
    byte_t             held_data;
    logic              held_last;
    logic              in_frame;
    int                frames_done;
    int                done_cnt;
    int                stall_cnt;
    int                err_cnt;
    int                errs_before;
    int                test_cnt;
    int                fail_cnt;
    int                cycle_cnt;

    tb_clock_gen clock_gen_inst (
        .axi_clk  (axi_clk),
        .axi_rstn (axi_rstn)
    );

    udp_arp_tx udp_arp_tx_inst (
        .axi_clk      (axi_clk),
        .axi_rstn     (axi_rstn),
        .i_wdata      (i_wdata),
        .i_wvalid     (i_wvalid),
        .i_wlast      (i_wlast),
        .o_wready     (o_wready),
        .o_done       (o_done),
        .i_arp_req    (i_arp_req),
        .i_target_mac (i_target_mac),
        .i_target_ip  (i_target_ip),
        .o_tdata      (o_tdata),
        .o_tvalid     (o_tvalid),
        .o_tlast      (o_tlast),
        .i_tready     (i_tready)
    );

    // End-around carry addition of two 16-bit words
    function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + {15'd0, s[16]};
    endfunction

    // Low count bytes of value, most significant first
    task automatic push_bytes(input logic [63:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            exp_q.push_back(value[8*i +: 8]);
            exp_last_q.push_back(1'b0);
        end
    endtask

    task automatic build_udp_frame(input logic [47:0] mac, input logic [31:0] ip);
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        logic [15:0] ip_sum;
        logic [15:0] udp_sum;
        ip_len  = 16'(pay_q.size() * 8 + 28);
        udp_len = 16'(pay_q.size() * 8 + 8);
        ip_sum  = ones_add(IP_VER_TOS, ip_len);
        ip_sum  = ones_add(ip_sum, next_id);
        ip_sum  = ones_add(ip_sum, IP_FLAGS);
        ip_sum  = ones_add(ip_sum, IP_TTL_PROTO);
        ip_sum  = ones_add(ip_sum, LOCAL_IP[31:16]);
        ip_sum  = ones_add(ip_sum, LOCAL_IP[15:0]);
        ip_sum  = ones_add(ip_sum, ip[31:16]);
        ip_sum  = ones_add(ip_sum, ip[15:0]);
        // Pseudo-header, then UDP header with a zero checksum
        udp_sum = ones_add(LOCAL_IP[31:16], LOCAL_IP[15:0]);
        udp_sum = ones_add(udp_sum, ip[31:16]);
        udp_sum = ones_add(udp_sum, ip[15:0]);
        udp_sum = ones_add(udp_sum, 16'd17);
        udp_sum = ones_add(udp_sum, udp_len);
        udp_sum = ones_add(udp_sum, 16'd8080);
        udp_sum = ones_add(udp_sum, 16'd8080);
        udp_sum = ones_add(udp_sum, udp_len);
        foreach (pay_q[w]) begin
            for (int k = 3; k >= 0; k--) begin
                udp_sum = ones_add(udp_sum, pay_q[w][16*k +: 16]);
            end
        end
        push_bytes(64'(mac), 6);
        push_bytes(64'(LOCAL_MAC), 6);
        push_bytes(64'h0800, 2);
        push_bytes(64'(IP_VER_TOS), 2);
        push_bytes(64'(ip_len), 2);
        push_bytes(64'(next_id), 2);
        push_bytes(64'(IP_FLAGS), 2);
        push_bytes(64'(IP_TTL_PROTO), 2);
        push_bytes(64'(~ip_sum), 2);
        push_bytes(64'(LOCAL_IP), 4);
        push_bytes(64'(ip), 4);
        push_bytes(64'd8080, 2);
        push_bytes(64'd8080, 2);
        push_bytes(64'(udp_len), 2);
        push_bytes(64'(~udp_sum), 2);
        foreach (pay_q[w]) push_bytes(pay_q[w], 8);
        exp_last_q[exp_last_q.size() - 1] = 1'b1;
        next_id = next_id + 16'd1;
    endtask

    task automatic build_arp_reply(input logic [47:0] mac, input logic [31:0] ip);
        push_bytes(64'(mac), 6);
        push_bytes(64'(LOCAL_MAC), 6);
        push_bytes(64'h0806, 2);
        push_bytes(64'h0001_0800_0604, 6);   // Ethernet, IPv4, address sizes
        push_bytes(64'h0002, 2);
        push_bytes(64'(LOCAL_MAC), 6);
        push_bytes(64'(LOCAL_IP), 4);
        push_bytes(64'(mac), 6);
        push_bytes(64'(ip), 4);
        exp_last_q[exp_last_q.size() - 1] = 1'b1;
    endtask

    `include "tb_tests.svh"

    always begin
        @(posedge axi_clk);
        #2;
        if (rand_ready) i_tready = (($urandom % 3) != 0);
        else            i_tready = 1'b1;
    end

    // Collector, sampled mid-cycle where DUT outputs are settled
    always @(negedge axi_clk) begin
        if (axi_rstn) begin
            if (hold_pending && (!o_tvalid || o_tdata !== held_data || o_tlast !== held_last)) begin
                $display("[ERROR] %0t: output byte changed while i_tready was low", $time);
                err_cnt++;
            end
            if (in_frame && !o_tvalid) begin
                $display("[ERROR] %0t: o_tvalid dropped inside a frame", $time);
                err_cnt++;
            end
            hold_pending = o_tvalid && !i_tready;
            held_data    = o_tdata;
            held_last    = o_tlast;
            if (hold_pending) stall_cnt++;
            if (o_tvalid && i_tready) begin
                got_q.push_back(o_tdata);
                got_last_q.push_back(o_tlast);
                in_frame = !o_tlast;
                if (o_tlast) frames_done++;
            end
            if (o_done) done_cnt++;
        end
    end

    always @(posedge axi_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped sending frames", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        i_wdata      = '0;
        i_wvalid     = 1'b0;
        i_wlast      = 1'b0;
        i_arp_req    = 1'b0;
        i_target_mac = '0;
        i_target_ip  = '0;
        i_tready     = 1'b1;
        rand_ready   = 1'b0;
        hold_pending = 1'b0;
        held_data    = '0;
        held_last    = 1'b0;
        in_frame     = 1'b0;
        next_id      = '0;
        frames_done  = 0;
        done_cnt     = 0;
        stall_cnt    = 0;
        err_cnt      = 0;
        errs_before  = 0;
        test_cnt     = 0;
        fail_cnt     = 0;
        cycle_cnt    = 0;
        void'($urandom(SEED));
        @(posedge axi_rstn);
        @(posedge axi_clk);
        #2;
        test_reset_state();
        test_single_frame();
        test_back_to_back();
        test_back_pressure();
        test_arp_reply();
        test_arp_behind_udp();
        $display("Summary: %0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic axi_clk,
    output logic axi_rstn
);
    localparam int HALF_PERIOD  = 20;      // 40 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        axi_clk = 1'b0;
        forever #HALF_PERIOD axi_clk = ~axi_clk;
    end

    initial begin
        axi_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge axi_clk);
        #2 axi_rstn = 1'b1;                // Released just after the edge like other inputs
    end

endmodule

// File: logic/udp_arp_tx.sv
`timescale 1ns/1ps

module udp_arp_tx (
    input  logic                          axi_clk,
    input  logic                          axi_rstn,
    input  logic [udp_tx_pkg::DATA_W-1:0] i_wdata,
    input  logic                          i_wvalid,
    input  logic                          i_wlast,
    output logic                          o_wready,
    output logic                          o_done,
    input  logic                          i_arp_req,
    input  logic [47:0]                   i_target_mac,
    input  logic [31:0]                   i_target_ip,
    output udp_tx_pkg::byte_t             o_tdata,
    output logic                          o_tvalid,
    output logic                          o_tlast,
    input  logic                          i_tready
);
    import udp_tx_pkg::*;

    logic           push;
    payload_word_t  push_word;
    logic           fifo_full;
    logic           fifo_empty;
    logic           fifo_pop;
    payload_word_t  fifo_word;
    logic           sum_valid;
    logic           sum_take;
    frame_summary_t summary;
    logic           hdr_valid;
    logic           hdr_take;
    tx_header_t     header;

    payload_intake payload_intake_inst (
        .axi_clk     (axi_clk),
        .axi_rstn    (axi_rstn),
        .i_wdata     (i_wdata),
        .i_wvalid    (i_wvalid),
        .i_wlast     (i_wlast),
        .i_fifo_full (fifo_full),
        .i_sum_take  (sum_take),
        .o_wready    (o_wready),
        .o_push      (push),
        .o_push_word (push_word),
        .o_sum_valid (sum_valid),
        .o_summary   (summary),
        .o_done      (o_done)
    );

    // Payload words wait here until their header is ready
    word_fifo #(.entry_t(payload_word_t)) word_fifo_inst (
        .axi_clk     (axi_clk),
        .axi_rstn    (axi_rstn),
        .i_push      (push),
        .i_push_data (push_word),
        .i_pop       (fifo_pop),
        .o_pop_data  (fifo_word),
        .o_empty     (fifo_empty),
        .o_full      (fifo_full)
    );

    checksum_calc checksum_calc_inst (
        .axi_clk      (axi_clk),
        .axi_rstn     (axi_rstn),
        .i_sum_valid  (sum_valid),
        .i_summary    (summary),
        .i_target_mac (i_target_mac),
        .i_target_ip  (i_target_ip),
        .i_hdr_take   (hdr_take),
        .o_sum_take   (sum_take),
        .o_hdr_valid  (hdr_valid),
        .o_header     (header)
    );

    frame_serializer frame_serializer_inst (
        .axi_clk      (axi_clk),
        .axi_rstn     (axi_rstn),
        .i_hdr_valid  (hdr_valid),
        .i_header     (header),
        .i_fifo_word  (fifo_word),
        .i_fifo_empty (fifo_empty),
        .i_arp_req    (i_arp_req),
        .i_tready     (i_tready),
        .o_hdr_take   (hdr_take),
        .o_fifo_pop   (fifo_pop),
        .o_tdata      (o_tdata),
        .o_tvalid     (o_tvalid),
        .o_tlast      (o_tlast)
    );

endmodule

// File: logic/frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer (
    input  logic                      axi_clk,
    input  logic                      axi_rstn,
    input  logic                      i_hdr_valid,
    input  udp_tx_pkg::tx_header_t    i_header,
    input  udp_tx_pkg::payload_word_t i_fifo_word,
    input  logic                      i_fifo_empty,
    input  logic                      i_arp_req,
    input  logic                      i_tready,
    output logic                      o_hdr_take,
    output logic                      o_fifo_pop,
    output udp_tx_pkg::byte_t         o_tdata,
    output logic                      o_tvalid,
    output logic                      o_tlast
);
    import udp_tx_pkg::*;

    localparam int               IDX_W    = $clog2(WORD_BYTES);
    localparam logic [5:0]       ETH_LAST = 6'(ETH_HDR_LEN - 1);
    localparam logic [5:0]       IP_LAST  = 6'(IP_HDR_LEN - 1);
    localparam logic [5:0]       UDP_LAST = 6'(UDP_HDR_LEN - 1);
    localparam logic [5:0]       ARP_LAST = 6'(ARP_FRAME_LEN - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(WORD_BYTES - 1);

    typedef enum logic [2:0] {S_IDLE, S_ETH, S_IP, S_UDP, S_PAY, S_ARP} state_t;

    state_t           state;
    logic [5:0]       cnt;          // Byte within the current header
    logic [IDX_W-1:0] byte_idx;     // Byte within the payload word
    logic             arp_pend;
    logic             arp_start;
    logic             adv;
    logic             cnt_end;
    tx_header_t       hdr_r;

    logic [111:0] eth_vec;
    logic [159:0] ip_vec;
    logic [63:0]  udp_vec;
    logic [335:0] arp_vec;

    assign eth_vec = {hdr_r.target_mac, LOCAL_MAC, ETH_TYPE_IP};
    assign ip_vec  = {IP_VER_TOS, hdr_r.ip_len, hdr_r.ip_id, IP_FLAGS, IP_TTL_PROTO,
                      hdr_r.ip_csum, LOCAL_IP, hdr_r.target_ip};
    assign udp_vec = {LOCAL_SP, LOCAL_DP, hdr_r.udp_len, hdr_r.udp_csum};
    assign arp_vec = {hdr_r.target_mac, LOCAL_MAC, ETH_TYPE_ARP, ARP_HW_PROTO, ARP_OP_REPLY,
                      LOCAL_MAC, LOCAL_IP, hdr_r.target_mac, hdr_r.target_ip};

    // A waiting header wins over a pending ARP request
    assign o_hdr_take = (state == S_IDLE) && i_hdr_valid;
    assign arp_start  = (state == S_IDLE) && !i_hdr_valid && arp_pend;

    assign o_tvalid = (state != S_IDLE);
    // Empty FIFO cannot occur here since payload is buffered before the header
    assign adv        = o_tvalid && i_tready && !((state == S_PAY) && i_fifo_empty);
    assign o_fifo_pop = (state == S_PAY) && adv && (byte_idx == IDX_LAST);
    assign o_tlast    = ((state == S_PAY) && (byte_idx == IDX_LAST) && i_fifo_word.last)
                     || ((state == S_ARP) && (cnt == ARP_LAST));

    always_comb begin
        o_tdata = '0;
        cnt_end = 1'b0;
        case (state)
            S_ETH: begin
                o_tdata = eth_vec[8*(ETH_LAST - cnt) +: 8];
                cnt_end = (cnt == ETH_LAST);
            end
            S_IP: begin
                o_tdata = ip_vec[8*(IP_LAST - cnt) +: 8];
                cnt_end = (cnt == IP_LAST);
            end
            S_UDP: begin
                o_tdata = udp_vec[8*(UDP_LAST - cnt) +: 8];
                cnt_end = (cnt == UDP_LAST);
            end
            S_PAY:   o_tdata = i_fifo_word.data[8*(IDX_LAST - byte_idx) +: 8]; // MSB first
            S_ARP: begin
                o_tdata = arp_vec[8*(ARP_LAST - cnt) +: 8];
                cnt_end = (cnt == ARP_LAST);
            end
            default: ;
        endcase
    end

    always_ff @(posedge axi_clk) begin
        if (!axi_rstn) begin
            state    <= S_IDLE;
            cnt      <= '0;
            byte_idx <= '0;
            arp_pend <= 1'b0;
        end else begin
            arp_pend <= i_arp_req || (arp_pend && !arp_start);
            if (state == S_IDLE) begin
                cnt      <= '0;
                byte_idx <= '0;
                if (o_hdr_take) begin
                    state <= S_ETH;
                end else if (arp_start) begin
                    state <= S_ARP;
                end
            end else if (adv) begin
                if (state == S_PAY) begin
                    byte_idx <= byte_idx + 1'b1;
                    if (o_tlast) state <= S_IDLE;
                end else if (cnt_end) begin
                    cnt <= '0;
                    case (state)
                        S_ETH:   state <= S_IP;
                        S_IP:    state <= S_UDP;
                        S_UDP:   state <= S_PAY;
                        default: state <= S_IDLE;   // End of ARP reply
                    endcase
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // ARP start also latches the target addresses
    always_ff @(posedge axi_clk) begin
        if (o_hdr_take || arp_start) hdr_r <= i_header;
    end

endmodule

// File: logic/checksum_calc.sv
`timescale 1ns/1ps

module checksum_calc (
    input  logic                       axi_clk,
    input  logic                       axi_rstn,
    input  logic                       i_sum_valid,
    input  udp_tx_pkg::frame_summary_t i_summary,
    input  logic [47:0]                i_target_mac,
    input  logic [31:0]                i_target_ip,
    input  logic                       i_hdr_take,
    output logic                       o_sum_take,
    output logic                       o_hdr_valid,
    output udp_tx_pkg::tx_header_t     o_header
);
    import udp_tx_pkg::*;

    logic [1:0]  step;         // 0 idle, 1 to 3 accumulating
    logic        busy;
    logic [15:0] ip_id;
    logic [31:0] word_sum;
    logic [31:0] ip_acc;
    logic [31:0] udp_acc;
    logic [16:0] tip_sum;

    function automatic logic [15:0] fold16(input logic [31:0] s);
        logic [16:0] t;
        t = {1'b0, s[31:16]} + {1'b0, s[15:0]};
        return t[15:0] + 16'(t[16]);
    endfunction

    assign busy       = (step != 2'd0) || o_hdr_valid;
    assign o_sum_take = i_sum_valid && !busy;
    assign tip_sum    = {1'b0, o_header.target_ip[31:16]} + {1'b0, o_header.target_ip[15:0]};

    always_ff @(posedge axi_clk) begin
        if (!axi_rstn) begin
            step        <= 2'd0;
            o_hdr_valid <= 1'b0;
            ip_id       <= '0;
        end else begin
            if (i_hdr_take) o_hdr_valid <= 1'b0;
            case (step)
                2'd0:    if (o_sum_take) step <= 2'd1;
                2'd3: begin
                    step        <= 2'd0;
                    o_hdr_valid <= 1'b1;
                    ip_id       <= ip_id + 1'b1;      // One id per header
                end
                default: step <= step + 1'b1;
            endcase
        end
    end

    always_ff @(posedge axi_clk) begin
        // Targets follow the inputs while idle, so an ARP reply sees them too
        if (!busy) begin
            o_header.target_mac <= i_target_mac;
            o_header.target_ip  <= i_target_ip;
        end
        if (o_sum_take) begin
            word_sum         <= i_summary.word_sum;
            o_header.ip_len  <= i_summary.byte_cnt + IP_HDR_LEN + UDP_HDR_LEN;
            o_header.udp_len <= i_summary.byte_cnt + UDP_HDR_LEN;
            ip_acc           <= IP_LOCAL_SUM;
            udp_acc          <= UDP_LOCAL_SUM;
        end
        case (step)
            2'd1: begin
                ip_acc  <= ip_acc + 32'(tip_sum) + 32'(ip_id) + 32'(o_header.ip_len);
                // UDP length appears in the pseudo-header and in the UDP header
                udp_acc <= udp_acc + 32'(tip_sum) + {15'd0, o_header.udp_len, 1'b0};
            end
            2'd2: udp_acc <= udp_acc + word_sum;
            2'd3: begin
                o_header.ip_id    <= ip_id;
                o_header.ip_csum  <= ~fold16(ip_acc);
                o_header.udp_csum <= ~fold16(udp_acc);
            end
            default: ;
        endcase
    end

endmodule

// File: logic/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
    parameter type entry_t = logic [udp_tx_pkg::DATA_W-1:0],
    parameter int  DEPTH   = udp_tx_pkg::FIFO_DEPTH
) (
    input  logic   axi_clk,
    input  logic   axi_rstn,
    input  logic   i_push,
    input  entry_t i_push_data,
    input  logic   i_pop,
    output entry_t o_pop_data,
    output logic   o_empty,
    output logic   o_full
);
    localparam int AW = $clog2(DEPTH);

    entry_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push    = i_push && !o_full;
    assign do_pop     = i_pop && !o_empty;
    assign o_empty    = (count == '0);
    assign o_full     = (count == (AW+1)'(DEPTH));
    assign o_pop_data = mem[rd_ptr];     // Head entry, no read latency

    always_ff @(posedge axi_clk) begin
        if (!axi_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge axi_clk) begin
        if (do_push) mem[wr_ptr] <= i_push_data;
    end

endmodule

// File: logic/payload_intake.sv
`timescale 1ns/1ps

module payload_intake (
    input  logic                          axi_clk,
    input  logic                          axi_rstn,
    input  logic [udp_tx_pkg::DATA_W-1:0] i_wdata,
    input  logic                          i_wvalid,
    input  logic                          i_wlast,
    input  logic                          i_fifo_full,
    input  logic                          i_sum_take,
    output logic                          o_wready,
    output logic                          o_push,
    output udp_tx_pkg::payload_word_t     o_push_word,
    output logic                          o_sum_valid,
    output udp_tx_pkg::frame_summary_t    o_summary,
    output logic                          o_done
);
    import udp_tx_pkg::*;

    logic        accept;
    logic [17:0] word_sum;     // Four 16-bit halves, two carry bits
    logic [15:0] byte_acc;
    logic [31:0] sum_acc;

    // Stall while a summary waits or the FIFO is full
    assign o_wready = !o_sum_valid && !i_fifo_full;
    assign accept   = i_wvalid && o_wready;

    assign o_push      = accept;
    assign o_push_word = '{last: i_wlast, data: i_wdata};

    always_comb begin
        word_sum = '0;
        for (int i = 0; i < WORD_BYTES / 2; i++) begin
            word_sum = word_sum + 18'(i_wdata[16*i +: 16]);
        end
    end

    always_ff @(posedge axi_clk) begin
        if (!axi_rstn) begin
            byte_acc    <= '0;
            sum_acc     <= '0;
            o_sum_valid <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_done <= accept && i_wlast;
            if (i_sum_take) begin
                o_sum_valid <= 1'b0;
            end
            if (accept) begin
                if (i_wlast) begin
                    byte_acc    <= '0;                  // Ready for the next frame
                    sum_acc     <= '0;
                    o_sum_valid <= 1'b1;
                end else begin
                    byte_acc <= byte_acc + 16'(WORD_BYTES);
                    sum_acc  <= sum_acc + 32'(word_sum);
                end
            end
        end
    end

    // Totals include the last word itself
    always_ff @(posedge axi_clk) begin
        if (accept && i_wlast) begin
            o_summary.byte_cnt <= byte_acc + 16'(WORD_BYTES);
            o_summary.word_sum <= sum_acc + 32'(word_sum);
        end
    end

endmodule

// File: logic/udp_tx_pkg.sv
package udp_tx_pkg;

    localparam int DATA_W     = 64;
    localparam int WORD_BYTES = DATA_W / 8;
    localparam int FIFO_DEPTH = 64;            // 512 payload bytes per frame at most

    // Local station
    localparam logic [47:0] LOCAL_MAC = 48'h02_1A_2B_3C_4D_5E;
    localparam logic [31:0] LOCAL_IP  = 32'hC0A8_0064;
    localparam logic [15:0] LOCAL_SP  = 16'd8080;
    localparam logic [15:0] LOCAL_DP  = 16'd8080;

    localparam logic [15:0] ETH_TYPE_IP  = 16'h0800;
    localparam logic [15:0] ETH_TYPE_ARP = 16'h0806;
    localparam logic [15:0] IP_VER_TOS   = 16'h4500;   // Version 4, IHL 5, TOS 0
    localparam logic [15:0] IP_FLAGS     = 16'h4000;   // Don't fragment
    localparam logic [15:0] IP_TTL_PROTO = 16'h8011;   // TTL 0x80, UDP

    // HTYPE 1, PTYPE IPv4, HLEN 6, PLEN 4
    localparam logic [47:0] ARP_HW_PROTO = 48'h0001_0800_0604;
    localparam logic [15:0] ARP_OP_REPLY = 16'h0002;

    localparam logic [15:0] ETH_HDR_LEN   = 16'd14;
    localparam logic [15:0] IP_HDR_LEN    = 16'd20;
    localparam logic [15:0] UDP_HDR_LEN   = 16'd8;
    localparam logic [15:0] ARP_FRAME_LEN = 16'd42;

    // Header words that never change, summed ahead of time
    localparam logic [31:0] IP_LOCAL_SUM = 32'(IP_VER_TOS) + 32'(IP_FLAGS)
                                         + 32'(IP_TTL_PROTO)
                                         + 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0]);

    // Pseudo-header source IP and protocol, plus both ports
    localparam logic [31:0] UDP_LOCAL_SUM = 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0])
                                          + 32'(IP_TTL_PROTO[7:0])
                                          + 32'(LOCAL_SP) + 32'(LOCAL_DP);

    typedef logic [7:0] byte_t;

    typedef struct packed {
        logic              last;
        logic [DATA_W-1:0] data;
    } payload_word_t;

    typedef struct packed {
        logic [15:0] byte_cnt;     // Payload bytes
        logic [31:0] word_sum;     // Unfolded sum of payload 16-bit words
    } frame_summary_t;

    typedef struct packed {
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        logic [15:0] ip_id;
        logic [15:0] ip_csum;
        logic [15:0] udp_csum;
        logic [47:0] target_mac;
        logic [31:0] target_ip;
    } tx_header_t;

endpackage
